/* list.f */
+incdir+common
common/isa_pkg.sv
common/sb_pkg.sv
common/issue_if.sv
design/inst_decoder.sv
scoreboard/scoreboard_ctrl.sv
scoreboard/fu_status_table.sv
scoreboard/reg_status_table.sv
design/scoreboard_top.sv
bench/tb_scoreboard.sv

/* bench/tb_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_cfg.svh"

module tb_scoreboard;
    import isa_pkg::*;
    import sb_pkg::*;

    localparam int num_inst = 400;
    // worst case per instruction is issue, dispatch, 6 cycles of latency and writeback
    localparam int max_cycles = num_inst * 12;

    logic     clk;
    logic     rst;
    inst_t    inst;
    logic     inst_valid;
    fu_mask_t fu_done;
    logic     issue_ready;
    fu_mask_t dispatch_en;
    fu_op_t   dispatch_op;
    reg_idx_t dispatch_rs1;
    reg_idx_t dispatch_rs2;
    logic     wb_valid;
    fu_id_e   wb_fu;
    reg_idx_t wb_rd;

    // reference model indexed 0..3 in ALU, MEM, MUL, DIV order
    int     m_busy [`SB_NUM_FU];
    int     m_disp [`SB_NUM_FU];
    int     m_done [`SB_NUM_FU];
    int     m_dst [`SB_NUM_FU];
    int     m_src1 [`SB_NUM_FU];
    int     m_src2 [`SB_NUM_FU];
    // producer unit an operand still waits for or -1
    int     m_wait1 [`SB_NUM_FU];
    int     m_wait2 [`SB_NUM_FU];
    fu_op_t m_op [`SB_NUM_FU];
    // tag is unit index plus one and zero when nothing is pending
    int     m_tag [`SB_NUM_REGS];
    int     m_run;
    int     resp_cnt [`SB_NUM_FU];

    // instruction on the bus and what decode should make of it
    inst_t  cur_inst;
    int     cur_fu;
    fu_op_t cur_op;
    int     cur_rd;
    int     cur_rs1;
    int     cur_rs2;
    int     have_inst;

    int err_cnt;
    int cycles;
    int gen_cnt;
    int consumed;
    int accepted;
    int disp_cnt;
    int wb_cnt;
    int timed_out;

    scoreboard_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .fu_done      (fu_done),
        .issue_ready  (issue_ready),
        .dispatch_en  (dispatch_en),
        .dispatch_op  (dispatch_op),
        .dispatch_rs1 (dispatch_rs1),
        .dispatch_rs2 (dispatch_rs2),
        .wb_valid     (wb_valid),
        .wb_fu        (wb_fu),
        .wb_rd        (wb_rd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("Error: %s expected %0h actual %0h at %0t", name, expected, actual, $time);
        err_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("Error: %s at %0t", msg, $time);
        err_cnt++;
    endtask

    // random supported instruction on x0..x7 and now and then an unsupported word
    task automatic make_inst();
        int          kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        kind = $urandom % 16;
        f3   = $urandom % 8;
        rd   = $urandom % 8;
        rs1  = $urandom % 8;
        rs2  = $urandom % 8;
        alt  = $urandom % 2;
        imm  = $urandom;
        cur_fu  = -1;
        cur_op  = '0;
        cur_rd  = rd;
        cur_rs1 = rs1;
        cur_rs2 = rs2;
        if (kind < 5) begin
            // only ADD/SUB and SRL/SRA have a second encoding
            if (f3 != 3'd0 && f3 != 3'd5) begin
                alt = 1'b0;
            end
            cur_inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
            cur_fu   = 0;
            cur_op   = {1'b0, alt, f3};
        end else if (kind < 7) begin
            if (f3 == 3'd1) begin
                imm = {7'b0, imm[4:0]};
                alt = 1'b0;
            end else if (f3 == 3'd5) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            end else begin
                alt = 1'b0;
            end
            cur_inst = {imm, rs1, f3, rd, OP_IMM};
            cur_fu   = 0;
            cur_op   = {1'b1, alt, f3};
            cur_rs2  = 0;
        end else if (kind < 11) begin
            // MUL group below DIV group in funct3
            f3       = {(kind >= 9), f3[1:0]};
            cur_inst = {7'h01, rs2, rs1, f3, rd, OP};
            cur_fu   = (kind >= 9) ? 3 : 2;
            cur_op   = {2'b00, f3};
        end else if (kind < 13) begin
            case ($urandom % 5)
                0: f3 = 3'd0;
                1: f3 = 3'd1;
                2: f3 = 3'd2;
                3: f3 = 3'd4;
                default: f3 = 3'd5;
            endcase
            cur_inst = {imm, rs1, f3, rd, LOAD};
            cur_fu   = 1;
            cur_op   = {2'b00, f3};
            cur_rs2  = 0;
        end else if (kind < 15) begin
            f3       = $urandom % 3;
            cur_inst = {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
            cur_fu   = 1;
            cur_op   = {2'b01, f3};
            cur_rd   = 0;
        end else begin
            case ($urandom % 3)
                0: cur_inst = {imm, rs1, f3, rd, 7'b1100011};
                1: cur_inst = {imm, rs1, 3'd3, rd, LOAD};
                default: cur_inst = {7'h40, rs2, rs1, f3, rd, OP};
            endcase
        end
    endtask

    task automatic drive_inputs();
        fu_mask_t d;
        d = '0;
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (resp_cnt[u] > 0) begin
                resp_cnt[u]--;
                if (resp_cnt[u] == 0) begin
                    d[u] = 1'b1;
                end
            end
        end
        fu_done = d;
        if (have_inst == 0 && gen_cnt < num_inst && ($urandom % 4) != 0) begin
            make_inst();
            have_inst = 1;
            gen_cnt++;
        end
        if (have_inst != 0) begin
            inst       = cur_inst;
            inst_valid = 1'b1;
        end else begin
            // all-zero word decodes to no unit
            inst       = '0;
            inst_valid = 1'b0;
            cur_fu     = -1;
            cur_rd     = 0;
        end
    endtask

    // compare outputs with the model and advance it past the next edge
    task automatic check_cycle();
        logic     exp_ready;
        logic     exp_wb;
        logic     war_ok;
        logic     take;
        fu_mask_t exp_en;
        int       ed;
        int       ew;
        int       obs_d;
        int       obs_g;
        int       w1;
        int       w2;
        exp_ready = 1'b0;
        if (m_run != 0) begin
            if (cur_fu < 0) begin
                exp_ready = 1'b1;
            end else if (m_busy[cur_fu] == 0 && (cur_rd == 0 || m_tag[cur_rd] == 0)) begin
                exp_ready = 1'b1;
            end
        end
        if (issue_ready !== exp_ready) begin
            report_mismatch("issue_ready", exp_ready, issue_ready);
        end
        ed = -1;
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (ed < 0 && m_busy[u] != 0 && m_disp[u] == 0 &&
                m_wait1[u] < 0 && m_wait2[u] < 0) begin
                ed = u;
            end
        end
        exp_en = '0;
        if (ed >= 0) begin
            exp_en[ed] = 1'b1;
        end
        if (dispatch_en !== exp_en) begin
            report_mismatch("dispatch_en", exp_en, dispatch_en);
        end
        if (ed >= 0) begin
            if (dispatch_op !== m_op[ed]) begin
                report_mismatch("dispatch_op", m_op[ed], dispatch_op);
            end
            if (dispatch_rs1 !== reg_idx_t'(m_src1[ed])) begin
                report_mismatch("dispatch_rs1", m_src1[ed], dispatch_rs1);
            end
            if (dispatch_rs2 !== reg_idx_t'(m_src2[ed])) begin
                report_mismatch("dispatch_rs2", m_src2[ed], dispatch_rs2);
            end
        end
        // done and no other entry still has to read the old destination value
        ew = -1;
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            war_ok = 1'b1;
            for (int j = 0; j < `SB_NUM_FU; j++) begin
                if (j != i && m_dst[i] != 0 && m_busy[j] != 0 && m_disp[j] == 0) begin
                    if ((m_wait1[j] < 0 && m_src1[j] == m_dst[i]) ||
                        (m_wait2[j] < 0 && m_src2[j] == m_dst[i])) begin
                        war_ok = 1'b0;
                    end
                end
            end
            if (ew < 0 && m_busy[i] != 0 && m_done[i] != 0 && war_ok) begin
                ew = i;
            end
        end
        exp_wb = (ew >= 0);
        if (wb_valid !== exp_wb) begin
            report_mismatch("wb_valid", exp_wb, wb_valid);
        end
        if (ew >= 0 && wb_valid === 1'b1) begin
            if (int'(wb_fu) != ew + 1) begin
                report_mismatch("wb_fu", ew + 1, wb_fu);
            end
            if (wb_rd !== reg_idx_t'(m_dst[ew])) begin
                report_mismatch("wb_rd", m_dst[ew], wb_rd);
            end
        end
        obs_d = -1;
        if (dispatch_en !== '0) begin
            if ($onehot(dispatch_en)) begin
                for (int u = 0; u < `SB_NUM_FU; u++) begin
                    if (dispatch_en[u]) begin
                        obs_d = u;
                    end
                end
            end else begin
                report_failure("more than one dispatch_en bit is high");
            end
        end
        if (obs_d >= 0 && (m_busy[obs_d] == 0 || m_disp[obs_d] != 0)) begin
            report_failure("dispatch on a unit with no pending operand read");
            obs_d = -1;
        end
        obs_g = -1;
        if (wb_valid === 1'b1 && int'(wb_fu) >= 1 && int'(wb_fu) <= `SB_NUM_FU) begin
            obs_g = int'(wb_fu) - 1;
            if (m_busy[obs_g] == 0) begin
                report_failure("writeback granted to an idle unit");
                obs_g = -1;
            end
        end
        take = inst_valid && issue_ready === 1'b1 && cur_fu >= 0;
        w1 = -1;
        w2 = -1;
        // a producer written back in this cycle no longer holds the operand
        if (m_tag[cur_rs1] != 0 && m_tag[cur_rs1] != obs_g + 1) begin
            w1 = m_tag[cur_rs1] - 1;
        end
        if (m_tag[cur_rs2] != 0 && m_tag[cur_rs2] != obs_g + 1) begin
            w2 = m_tag[cur_rs2] - 1;
        end
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (fu_done[u] && m_busy[u] != 0) begin
                m_done[u] = 1;
            end
        end
        if (obs_d >= 0) begin
            m_disp[obs_d]   = 1;
            resp_cnt[obs_d] = 1 + $urandom % 6;
            disp_cnt++;
        end
        if (obs_g >= 0) begin
            m_busy[obs_g] = 0;
            m_done[obs_g] = 0;
            if (m_dst[obs_g] != 0 && m_tag[m_dst[obs_g]] == obs_g + 1) begin
                m_tag[m_dst[obs_g]] = 0;
            end
            for (int u = 0; u < `SB_NUM_FU; u++) begin
                if (m_wait1[u] == obs_g) begin
                    m_wait1[u] = -1;
                end
                if (m_wait2[u] == obs_g) begin
                    m_wait2[u] = -1;
                end
            end
            wb_cnt++;
        end
        if (take) begin
            m_busy[cur_fu]  = 1;
            m_disp[cur_fu]  = 0;
            m_done[cur_fu]  = 0;
            m_op[cur_fu]    = cur_op;
            m_dst[cur_fu]   = cur_rd;
            m_src1[cur_fu]  = cur_rs1;
            m_src2[cur_fu]  = cur_rs2;
            m_wait1[cur_fu] = w1;
            m_wait2[cur_fu] = w2;
            if (cur_rd != 0) begin
                m_tag[cur_rd] = cur_fu + 1;
            end
            accepted++;
        end
        // unsupported words leave the bus without touching the tables
        if (inst_valid && issue_ready === 1'b1) begin
            consumed++;
            have_inst = 0;
        end
        m_run = 1;
    endtask

    function automatic int all_idle();
        int idle;
        idle = (gen_cnt == num_inst && have_inst == 0) ? 1 : 0;
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (m_busy[u] != 0 || resp_cnt[u] != 0) begin
                idle = 0;
            end
        end
        return idle;
    endfunction

    initial begin
        void'($urandom(32'he8e8));
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        fu_done    = '0;
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            m_busy[u]   = 0;
            m_disp[u]   = 0;
            m_done[u]   = 0;
            m_dst[u]    = 0;
            m_src1[u]   = 0;
            m_src2[u]   = 0;
            m_wait1[u]  = -1;
            m_wait2[u]  = -1;
            m_op[u]     = '0;
            resp_cnt[u] = 0;
        end
        for (int r = 0; r < `SB_NUM_REGS; r++) begin
            m_tag[r] = 0;
        end
        m_run     = 0;
        cur_fu    = -1;
        cur_rd    = 0;
        cur_rs1   = 0;
        cur_rs2   = 0;
        have_inst = 0;
        err_cnt   = 0;
        cycles    = 0;
        gen_cnt   = 0;
        consumed  = 0;
        accepted  = 0;
        disp_cnt  = 0;
        wb_cnt    = 0;
        timed_out = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        drive_inputs();
        while (all_idle() == 0 && cycles < max_cycles) begin
            @(negedge clk);
            check_cycle();
            cycles++;
            @(posedge clk);
            #1;
            drive_inputs();
        end
        if (all_idle() == 0) begin
            timed_out = 1;
            $display("Error: run did not drain within %0d cycles", max_cycles);
        end else begin
            // drained with an idle bus and idle units
            @(negedge clk);
            check_cycle();
            if (dut_i.fus_i.busy !== '0) begin
                report_mismatch("busy", 0, dut_i.fus_i.busy);
            end
            if (wb_cnt != accepted) begin
                report_mismatch("writebacks", accepted, wb_cnt);
            end
        end
        $write("cycles %0d consumed %0d accepted %0d ", cycles, consumed, accepted);
        $display("dispatches %0d writebacks %0d errors %0d timeouts %0d",
                 disp_cnt, wb_cnt, err_cnt, timed_out);
        if (timed_out != 0 || err_cnt != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/scoreboard_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_cfg.svh"

module scoreboard_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire isa_pkg::inst_t      inst,
    input  wire                      inst_valid,
    input  wire sb_pkg::fu_mask_t    fu_done,
    output logic                     issue_ready,
    output sb_pkg::fu_mask_t         dispatch_en,
    output isa_pkg::fu_op_t          dispatch_op,
    output isa_pkg::reg_idx_t        dispatch_rs1,
    output isa_pkg::reg_idx_t        dispatch_rs2,
    output logic                     wb_valid,
    output sb_pkg::fu_id_e           wb_fu,
    output isa_pkg::reg_idx_t        wb_rd
);
    import isa_pkg::*;
    import sb_pkg::*;

    fu_id_e   tag1;
    fu_id_e   tag2;
    fu_id_e   rd_pending;
    fu_mask_t busy;
    fu_mask_t done;
    fu_mask_t rdy1;
    fu_mask_t rdy2;
    fu_mask_t wb_grant;
    reg_idx_t fu_dst [`SB_NUM_FU];
    reg_idx_t fu_src1 [`SB_NUM_FU];
    reg_idx_t fu_src2 [`SB_NUM_FU];

    issue_if iss ();

    inst_decoder dec_i (
        .inst       (inst),
        .inst_valid (inst_valid),
        .iss        (iss.dec)
    );

    scoreboard_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .iss         (iss.ctrl),
        .rd_pending  (rd_pending),
        .busy        (busy),
        .done        (done),
        .dst         (fu_dst),
        .src1        (fu_src1),
        .src2        (fu_src2),
        .rdy1        (rdy1),
        .rdy2        (rdy2),
        .issue_ready (issue_ready),
        .wb_grant    (wb_grant),
        .wb_valid    (wb_valid),
        .wb_fu       (wb_fu),
        .wb_rd       (wb_rd)
    );

    fu_status_table fus_i (
        .clk          (clk),
        .rst          (rst),
        .iss          (iss.tables),
        .tag1         (tag1),
        .tag2         (tag2),
        .fu_done      (fu_done),
        .wb_grant     (wb_grant),
        .busy         (busy),
        .done         (done),
        .dst          (fu_dst),
        .src1         (fu_src1),
        .src2         (fu_src2),
        .rdy1         (rdy1),
        .rdy2         (rdy2),
        .dispatch_en  (dispatch_en),
        .dispatch_op  (dispatch_op),
        .dispatch_rs1 (dispatch_rs1),
        .dispatch_rs2 (dispatch_rs2)
    );

    // granted destination comes from the writeback mux in ctrl
    reg_status_table rrs_i (
        .clk        (clk),
        .rst        (rst),
        .iss        (iss.tables),
        .wb_grant   (wb_grant),
        .wb_dst     (wb_rd),
        .tag1       (tag1),
        .tag2       (tag2),
        .rd_pending (rd_pending)
    );

endmodule

`default_nettype wire

/* scoreboard/reg_status_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_cfg.svh"

module reg_status_table (
    input  wire                      clk,
    input  wire                      rst,
    issue_if.tables                  iss,
    input  wire sb_pkg::fu_mask_t    wb_grant,
    input  wire isa_pkg::reg_idx_t   wb_dst,
    output sb_pkg::fu_id_e           tag1,
    output sb_pkg::fu_id_e           tag2,
    output sb_pkg::fu_id_e           rd_pending
);
    import sb_pkg::*;

    fu_tag_t rrs [`SB_NUM_REGS];
    fu_id_e  wb_id;

    assign wb_id      = mask_to_fu(wb_grant);
    assign tag1       = rrs[iss.rs1];
    assign tag2       = rrs[iss.rs2];
    assign rd_pending = rrs[iss.rd];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `SB_NUM_REGS; r++) begin
                rrs[r] <= NONE;
            end
        end else begin
            // tag may already belong to a newer producer
            if (wb_id != NONE && wb_dst != '0 && rrs[wb_dst] == wb_id) begin
                rrs[wb_dst] <= NONE;
            end
            // x0 stays untagged
            if (iss.accept && iss.rd != '0) begin
                rrs[iss.rd] <= iss.fu;
            end
        end
    end

endmodule

`default_nettype wire

/* scoreboard/fu_status_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_cfg.svh"

module fu_status_table (
    input  wire                      clk,
    input  wire                      rst,
    issue_if.tables                  iss,
    input  wire sb_pkg::fu_id_e      tag1,
    input  wire sb_pkg::fu_id_e      tag2,
    input  wire sb_pkg::fu_mask_t    fu_done,
    input  wire sb_pkg::fu_mask_t    wb_grant,
    output sb_pkg::fu_mask_t         busy,
    output sb_pkg::fu_mask_t         done,
    output isa_pkg::reg_idx_t        dst [`SB_NUM_FU],
    output isa_pkg::reg_idx_t        src1 [`SB_NUM_FU],
    output isa_pkg::reg_idx_t        src2 [`SB_NUM_FU],
    output sb_pkg::fu_mask_t         rdy1,
    output sb_pkg::fu_mask_t         rdy2,
    output sb_pkg::fu_mask_t         dispatch_en,
    output isa_pkg::fu_op_t          dispatch_op,
    output isa_pkg::reg_idx_t        dispatch_rs1,
    output isa_pkg::reg_idx_t        dispatch_rs2
);
    import isa_pkg::*;
    import sb_pkg::*;

    fu_op_t   op_q [`SB_NUM_FU];
    // producer still owed to each operand
    fu_tag_t  q1 [`SB_NUM_FU];
    fu_tag_t  q2 [`SB_NUM_FU];
    fu_mask_t iss_sel;
    fu_id_e   wb_id;
    logic     ready1_in;
    logic     ready2_in;

    assign iss_sel = iss.accept ? fu_to_mask(iss.fu) : '0;
    assign wb_id   = mask_to_fu(wb_grant);

    // producer writing back this cycle counts as already done
    assign ready1_in = (tag1 == NONE) || (tag1 == wb_id);
    assign ready2_in = (tag2 == NONE) || (tag2 == wb_id);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
            done <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
            for (int i = 0; i < `SB_NUM_FU; i++) begin
                q1[i] <= NONE;
                q2[i] <= NONE;
            end
        end else begin
            for (int i = 0; i < `SB_NUM_FU; i++) begin
                if (wb_grant[i]) begin
                    busy[i] <= 1'b0;
                    done[i] <= 1'b0;
                end else if (busy[i] && fu_done[i]) begin
                    done[i] <= 1'b1;
                end
                // operands read
                if (dispatch_en[i]) begin
                    rdy1[i] <= 1'b0;
                    rdy2[i] <= 1'b0;
                end
                // RAW wake-up
                if (wb_id != NONE && q1[i] == wb_id) begin
                    rdy1[i] <= 1'b1;
                    q1[i]   <= NONE;
                end
                if (wb_id != NONE && q2[i] == wb_id) begin
                    rdy2[i] <= 1'b1;
                    q2[i]   <= NONE;
                end
                if (iss_sel[i]) begin
                    busy[i] <= 1'b1;
                    done[i] <= 1'b0;
                    rdy1[i] <= ready1_in;
                    rdy2[i] <= ready2_in;
                    q1[i]   <= ready1_in ? NONE : tag1;
                    q2[i]   <= ready2_in ? NONE : tag2;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            if (iss_sel[i]) begin
                op_q[i] <= iss.op;
                dst[i]  <= iss.rd;
                src1[i] <= iss.rs1;
                src2[i] <= iss.rs2;
            end
        end
    end

    // read-operand select, ALU first
    always_comb begin
        logic hit;
        hit          = 1'b0;
        dispatch_en  = '0;
        dispatch_op  = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            if (!hit && rdy1[i] && rdy2[i]) begin
                hit            = 1'b1;
                dispatch_en[i] = 1'b1;
                dispatch_op    = op_q[i];
                dispatch_rs1   = src1[i];
                dispatch_rs2   = src2[i];
            end
        end
    end

endmodule

`default_nettype wire

/* scoreboard/scoreboard_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sb_cfg.svh"

module scoreboard_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    issue_if.ctrl                    iss,
    input  wire sb_pkg::fu_id_e      rd_pending,
    input  wire sb_pkg::fu_mask_t    busy,
    input  wire sb_pkg::fu_mask_t    done,
    input  wire isa_pkg::reg_idx_t   dst [`SB_NUM_FU],
    input  wire isa_pkg::reg_idx_t   src1 [`SB_NUM_FU],
    input  wire isa_pkg::reg_idx_t   src2 [`SB_NUM_FU],
    input  wire sb_pkg::fu_mask_t    rdy1,
    input  wire sb_pkg::fu_mask_t    rdy2,
    output logic                     issue_ready,
    output sb_pkg::fu_mask_t         wb_grant,
    output logic                     wb_valid,
    output sb_pkg::fu_id_e           wb_fu,
    output isa_pkg::reg_idx_t        wb_rd
);
    import sb_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } ctrl_state_e;

    ctrl_state_e state;
    logic        target_busy;
    fu_mask_t    war_ok;
    fu_mask_t    eligible;

    // hold off issue for the first cycle out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= RUN;
        end
    end

    // structural hazard and WAW on the decoded instruction
    assign target_busy = |(busy & fu_to_mask(iss.fu));
    assign issue_ready = (state == RUN) &&
                         (iss.fu == NONE ||
                          (!target_busy && (iss.rd == '0 || rd_pending == NONE)));
    assign iss.accept  = iss.valid && issue_ready && (iss.fu != NONE);

    // a set ready bit marks an operand that is still to be read
    always_comb begin
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            war_ok[i] = 1'b1;
            for (int j = 0; j < `SB_NUM_FU; j++) begin
                if (j != i && dst[i] != '0) begin
                    if ((rdy1[j] && src1[j] == dst[i]) || (rdy2[j] && src2[j] == dst[i])) begin
                        war_ok[i] = 1'b0;
                    end
                end
            end
        end
    end

    assign eligible = done & war_ok;

    // lowest index wins: ALU, MEM, MUL, DIV
    always_comb begin
        logic hit;
        hit      = 1'b0;
        wb_grant = '0;
        wb_rd    = '0;
        for (int i = 0; i < `SB_NUM_FU; i++) begin
            if (!hit && eligible[i]) begin
                hit         = 1'b1;
                wb_grant[i] = 1'b1;
                wb_rd       = dst[i];
            end
        end
    end

    assign wb_valid = |wb_grant;
    assign wb_fu    = mask_to_fu(wb_grant);

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire isa_pkg::inst_t inst,
    input  wire                 inst_valid,
    issue_if.dec                iss
);
    import isa_pkg::*;
    import sb_pkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;
    logic       f7_mext;
    fu_id_e     fu_sel;
    fu_op_t     op_sel;
    logic       uses_rd;
    logic       uses_rs2;

    assign funct7  = inst[31:25];
    assign funct3  = inst[14:12];
    assign f7_zero = (funct7 == 7'h00);
    assign f7_alt  = (funct7 == 7'h20);
    assign f7_mext = (funct7 == 7'h01);

    always_comb begin
        fu_sel   = NONE;
        op_sel   = '0;
        uses_rd  = 1'b1;
        uses_rs2 = 1'b0;
        case (inst[6:0])
            OP: begin
                uses_rs2 = 1'b1;
                if (f7_zero || (f7_alt && (funct3 == 3'd0 || funct3 == 3'd5))) begin
                    fu_sel = ALU;
                    op_sel = {1'b0, inst[30], funct3};
                end else if (f7_mext) begin
                    // funct3[2] splits MUL* from DIV*/REM*
                    fu_sel = funct3[2] ? DIV : MUL;
                    op_sel = {2'b00, funct3};
                end
            end
            OP_IMM: begin
                // alternate flag only means something for shifts
                if (funct3 == 3'd1) begin
                    fu_sel = f7_zero ? ALU : NONE;
                    op_sel = {2'b10, funct3};
                end else if (funct3 == 3'd5) begin
                    fu_sel = (f7_zero || f7_alt) ? ALU : NONE;
                    op_sel = {1'b1, inst[30], funct3};
                end else begin
                    fu_sel = ALU;
                    op_sel = {2'b10, funct3};
                end
            end
            LOAD: begin
                fu_sel = (funct3 == 3'd3 || funct3[2:1] == 2'b11) ? NONE : MEM;
                op_sel = {2'b00, funct3};
            end
            STORE: begin
                uses_rd  = 1'b0;
                uses_rs2 = 1'b1;
                fu_sel   = (funct3[2] || funct3 == 3'd3) ? NONE : MEM;
                op_sel   = {2'b01, funct3};
            end
            default: begin
                fu_sel = NONE;
            end
        endcase
    end

    assign iss.valid = inst_valid;
    assign iss.fu    = fu_sel;
    assign iss.op    = (fu_sel == NONE) ? '0 : op_sel;
    assign iss.rd    = (fu_sel != NONE && uses_rd) ? inst[11:7] : '0;
    assign iss.rs1   = (fu_sel != NONE) ? inst[19:15] : '0;
    assign iss.rs2   = (fu_sel != NONE && uses_rs2) ? inst[24:20] : '0;

endmodule

`default_nettype wire

/* common/issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
    import isa_pkg::*;
    import sb_pkg::*;

    logic     valid;
    fu_id_e   fu;
    fu_op_t   op;
    // zero when the field is unused
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     accept;

    modport dec (
        output valid, fu, op, rd, rs1, rs2
    );

    modport ctrl (
        input  valid, fu, rd,
        output accept
    );

    modport tables (
        input valid, fu, op, rd, rs1, rs2, accept
    );

endinterface

`default_nettype wire

/* common/sb_pkg.sv */
`default_nettype none

`include "sb_cfg.svh"

package sb_pkg;

    // unit ids, also used as register result tags
    typedef enum logic [2:0] {
        NONE = 3'd0,
        ALU  = 3'd1,
        MEM  = 3'd2,
        MUL  = 3'd3,
        DIV  = 3'd4
    } fu_id_e;

    // bit 0 ALU, bit 1 MEM, bit 2 MUL, bit 3 DIV
    typedef logic [`SB_NUM_FU-1:0] fu_mask_t;

    // unit that will produce a pending register value
    typedef fu_id_e fu_tag_t;

    function automatic fu_mask_t fu_to_mask(input fu_id_e fu);
        case (fu)
            ALU:     return 4'b0001;
            MEM:     return 4'b0010;
            MUL:     return 4'b0100;
            DIV:     return 4'b1000;
            default: return 4'b0000;
        endcase
    endfunction

    // expects a one-hot or empty mask
    function automatic fu_id_e mask_to_fu(input fu_mask_t mask);
        case (mask)
            4'b0001: return ALU;
            4'b0010: return MEM;
            4'b0100: return MUL;
            4'b1000: return DIV;
            default: return NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

`include "sb_cfg.svh"

package isa_pkg;

    typedef logic [31:0] inst_t;

    typedef logic [`SB_REG_W-1:0] reg_idx_t;

    // unit-relative operation code, see inst_decoder for the layout
    typedef logic [`SB_OP_W-1:0] fu_op_t;

    // major opcodes handled by the scoreboard
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011
    } opcode_e;

endpackage

`default_nettype wire

/* common/sb_cfg.svh */
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// function units: ALU, MEM, MUL, DIV
`define SB_NUM_FU   4

// architectural registers
`define SB_NUM_REGS 32
`define SB_REG_W    5

// per-unit operation code
`define SB_OP_W     5

`endif
